//--- logic/i2c_rx_pkg.sv
// shared widths, vector types, shifter state enum and address constants
// for the i2c slave receive path
`default_nettype none

package i2c_rx_pkg;

    // bus byte and address widths
    localparam int BYTE_W = 8;
    localparam int ADDR_W = 7;
    localparam int CNT_W  = 4;

    // eight data bits, counter loads one more for the ack slot
    localparam int BITS_PER_BYTE = 8;

    // depth of the scl/sda synchronizers
    localparam int SYNC_STAGES = 2;

    typedef logic [BYTE_W-1:0] rx_byte_t;
    typedef logic [ADDR_W-1:0] slave_addr_t;
    typedef logic [CNT_W-1:0]  bit_cnt_t;

    // general call address byte
    localparam rx_byte_t GCALL_ADDR = 8'h00;

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        ACK,
        DONE
    } rx_state_t;

endpackage

`default_nettype wire

//--- logic/i2c_rx_byte_if.sv
// byte link between the receive shifter and the address matcher
`timescale 1ns/1ps
`default_nettype none

interface i2c_rx_byte_if;

    i2c_rx_pkg::rx_byte_t rx_byte;
    logic                 byte_done;
    logic                 first_byte;
    logic                 stop_seen;
    logic                 match;

    modport shifter (
        output rx_byte,
        output byte_done,
        output first_byte,
        output stop_seen,
        input  match
    );

    modport matcher (
        input  rx_byte,
        input  byte_done,
        input  first_byte,
        input  stop_seen,
        output match
    );

endinterface

`default_nettype wire

//--- logic/i2c_rx_shifter.sv
// i2c receive shifter: line sync, start/stop detect, bit counter,
// shift fsm, ack drive on sda and fifo push
`timescale 1ns/1ps
`default_nettype none

module i2c_rx_shifter (
    input  logic                 i2c_clk,
    input  logic                 i2c_rst_n,
    input  logic                 scl_in,
    input  logic                 sda_in,
    input  logic                 enable,
    input  logic                 full,
    output logic                 sda_drive_low,
    output logic                 push,
    output i2c_rx_pkg::rx_byte_t push_data,
    i2c_rx_byte_if.shifter       byte_if
);

    localparam int SYNC_N = i2c_rx_pkg::SYNC_STAGES;
    localparam i2c_rx_pkg::bit_cnt_t CNT_LOAD =
        i2c_rx_pkg::bit_cnt_t'(i2c_rx_pkg::BITS_PER_BYTE + 1);
    // count value while the last data bit is sampled
    localparam i2c_rx_pkg::bit_cnt_t CNT_LAST = i2c_rx_pkg::bit_cnt_t'(2);

    logic [SYNC_N-1:0]         scl_sync;
    logic [SYNC_N-1:0]         sda_sync;
    logic                      scl_s;
    logic                      sda_s;
    logic                      scl_d;
    logic                      sda_d;
    logic                      scl_rise;
    logic                      scl_fall;
    logic                      start_det;
    logic                      stop_det;
    logic                      ack_ok;
    logic                      first_q;
    logic                      byte_done_q;
    logic                      stop_q;
    i2c_rx_pkg::rx_state_t     state;
    i2c_rx_pkg::bit_cnt_t      bit_cnt;
    i2c_rx_pkg::rx_byte_t      shift_q;

    // idle bus is high on both lines
    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            scl_sync <= '1;
            sda_sync <= '1;
            scl_d    <= 1'b1;
            sda_d    <= 1'b1;
        end else begin
            scl_sync <= {scl_sync[SYNC_N-2:0], scl_in};
            sda_sync <= {sda_sync[SYNC_N-2:0], sda_in};
            scl_d    <= scl_s;
            sda_d    <= sda_s;
        end
    end

    assign scl_s     = scl_sync[SYNC_N-1];
    assign sda_s     = sda_sync[SYNC_N-1];
    assign scl_rise  = scl_s & ~scl_d;
    assign scl_fall  = ~scl_s & scl_d;
    assign start_det = scl_s & scl_d & sda_d & ~sda_s;
    assign stop_det  = scl_s & scl_d & ~sda_d & sda_s;

    // address byte needs a match, data byte also needs room
    assign ack_ok = first_q ? byte_if.match : (byte_if.match & enable & ~full);

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            state         <= i2c_rx_pkg::IDLE;
            bit_cnt       <= '0;
            first_q       <= 1'b0;
            sda_drive_low <= 1'b0;
            push          <= 1'b0;
            byte_done_q   <= 1'b0;
            stop_q        <= 1'b0;
        end else begin
            push        <= 1'b0;
            byte_done_q <= 1'b0;
            stop_q      <= stop_det;
            if (stop_det) begin
                state         <= i2c_rx_pkg::IDLE;
                first_q       <= 1'b0;
                sda_drive_low <= 1'b0;
            end else if (start_det) begin
                state         <= i2c_rx_pkg::SHIFT;
                bit_cnt       <= CNT_LOAD;
                first_q       <= 1'b1;
                sda_drive_low <= 1'b0;
            end else begin
                case (state)
                    i2c_rx_pkg::SHIFT: begin
                        if (scl_rise) begin
                            bit_cnt <= bit_cnt - 1'b1;
                            if (bit_cnt == CNT_LAST) begin
                                state       <= i2c_rx_pkg::ACK;
                                byte_done_q <= 1'b1;
                            end
                        end
                    end
                    i2c_rx_pkg::ACK: begin
                        if (scl_rise && bit_cnt != '0) begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                        if (scl_fall && bit_cnt != '0) begin
                            // start of ack slot
                            sda_drive_low <= ack_ok;
                            push          <= ack_ok & ~first_q;
                        end else if (scl_fall) begin
                            sda_drive_low <= 1'b0;
                            first_q       <= 1'b0;
                            if (byte_if.match) begin
                                state   <= i2c_rx_pkg::SHIFT;
                                bit_cnt <= CNT_LOAD;
                            end else begin
                                // not addressed, wait for next start
                                state <= i2c_rx_pkg::DONE;
                            end
                        end
                    end
                    default: begin
                        state <= state;
                    end
                endcase
            end
        end
    end

    // msb first
    always_ff @(posedge i2c_clk) begin
        if (state == i2c_rx_pkg::SHIFT && scl_rise) begin
            shift_q <= {shift_q[i2c_rx_pkg::BYTE_W-2:0], sda_s};
        end
    end

    assign push_data          = shift_q;
    assign byte_if.rx_byte    = shift_q;
    assign byte_if.byte_done  = byte_done_q;
    assign byte_if.first_byte = first_q;
    assign byte_if.stop_seen  = stop_q;

endmodule

`default_nettype wire

//--- logic/i2c_addr_matcher.sv
// 7-bit address compare with stealing mask, general call compare
`timescale 1ns/1ps
`default_nettype none

module i2c_addr_matcher #(
    parameter int ADDRESS_STEALING = 0
) (
    input  logic                    i2c_clk,
    input  logic                    i2c_rst_n,
    input  logic                    enable,
    input  i2c_rx_pkg::slave_addr_t slave_addr,
    input  logic                    gen_call_en,
    output logic                    addr_matched,
    output logic                    gen_call_rcvd,
    i2c_rx_byte_if.matcher          byte_if
);

    // low address bits ignored in the compare
    localparam i2c_rx_pkg::slave_addr_t STEAL_MASK =
        ~i2c_rx_pkg::slave_addr_t'((1 << ADDRESS_STEALING) - 1);

    logic first_d;
    logic new_start;
    logic addr_hit;
    logic gcall_hit;
    logic match_q;

    assign new_start = byte_if.first_byte & ~first_d;

    // write direction only
    assign addr_hit = ((byte_if.rx_byte[i2c_rx_pkg::BYTE_W-1:1] & STEAL_MASK) ==
                       (slave_addr & STEAL_MASK)) && !byte_if.rx_byte[0];
    assign gcall_hit = gen_call_en && (byte_if.rx_byte == i2c_rx_pkg::GCALL_ADDR);

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            first_d       <= 1'b0;
            match_q       <= 1'b0;
            gen_call_rcvd <= 1'b0;
        end else begin
            first_d       <= byte_if.first_byte;
            gen_call_rcvd <= 1'b0;
            if (byte_if.stop_seen || new_start) begin
                match_q <= 1'b0;
            end else if (byte_if.byte_done && byte_if.first_byte) begin
                match_q       <= enable & (addr_hit | gcall_hit);
                gen_call_rcvd <= enable & gcall_hit;
            end
        end
    end

    assign addr_matched  = match_q;
    assign byte_if.match = match_q;

endmodule

`default_nettype wire

//--- logic/i2c_rx_fifo.sv
// circular receive buffer with full, empty and fill level
`timescale 1ns/1ps
`default_nettype none

module i2c_rx_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                       i2c_clk,
    input  logic                       i2c_rst_n,
    input  logic                       push,
    input  i2c_rx_pkg::rx_byte_t       push_data,
    input  logic                       pop,
    output i2c_rx_pkg::rx_byte_t       pop_data,
    output logic                       full,
    output logic                       empty,
    output logic [$clog2(FIFO_DEPTH):0] level
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int LVL_W = PTR_W + 1;

    i2c_rx_pkg::rx_byte_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic                 do_push;
    logic                 do_pop;

    assign full     = (level == LVL_W'(FIFO_DEPTH));
    assign empty    = (level == '0);
    assign do_push  = push & ~full;
    assign do_pop   = pop & ~empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge i2c_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap on the power of two depth
    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/i2c_rx_read_port.sv
// host read port: fifo pop, registered data, sticky underflow
`timescale 1ns/1ps
`default_nettype none

module i2c_rx_read_port (
    input  logic                 i2c_clk,
    input  logic                 i2c_rst_n,
    input  logic                 rd_en,
    input  i2c_rx_pkg::rx_byte_t pop_data,
    input  logic                 empty,
    output logic                 pop,
    output i2c_rx_pkg::rx_byte_t rd_data,
    output logic                 rd_valid,
    output logic                 underflow
);

    // only pop when something is there
    assign pop = rd_en & ~empty;

    always_ff @(posedge i2c_clk) begin
        if (pop) begin
            rd_data <= pop_data;
        end
    end

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            rd_valid  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            rd_valid <= pop;
            // held until reset
            if (rd_en && empty) begin
                underflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/i2c_slave_rx_top.sv
// i2c slave receive top: shifter with address matcher, rx fifo, read port
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_rx_top #(
    parameter int FIFO_DEPTH       = 4,
    parameter int ADDRESS_STEALING = 0
) (
    input  logic                        i2c_clk,
    input  logic                        i2c_rst_n,
    input  logic                        scl_in,
    input  logic                        sda_in,
    input  logic                        enable,
    input  i2c_rx_pkg::slave_addr_t     slave_addr,
    input  logic                        gen_call_en,
    input  logic                        rd_en,
    output logic                        sda_drive_low,
    output i2c_rx_pkg::rx_byte_t        rd_data,
    output logic                        rd_valid,
    output logic [$clog2(FIFO_DEPTH):0] fifo_level,
    output logic                        addr_matched,
    output logic                        gen_call_rcvd,
    output logic                        underflow
);

    logic                 push;
    i2c_rx_pkg::rx_byte_t push_data;
    logic                 full;
    logic                 pop;
    i2c_rx_pkg::rx_byte_t pop_data;
    logic                 empty;

    i2c_rx_byte_if byte_if ();

    i2c_rx_shifter u_shifter (
        .i2c_clk       (i2c_clk),
        .i2c_rst_n     (i2c_rst_n),
        .scl_in        (scl_in),
        .sda_in        (sda_in),
        .enable        (enable),
        .full          (full),
        .sda_drive_low (sda_drive_low),
        .push          (push),
        .push_data     (push_data),
        .byte_if       (byte_if.shifter)
    );

    i2c_addr_matcher #(
        .ADDRESS_STEALING (ADDRESS_STEALING)
    ) u_matcher (
        .i2c_clk       (i2c_clk),
        .i2c_rst_n     (i2c_rst_n),
        .enable        (enable),
        .slave_addr    (slave_addr),
        .gen_call_en   (gen_call_en),
        .addr_matched  (addr_matched),
        .gen_call_rcvd (gen_call_rcvd),
        .byte_if       (byte_if.matcher)
    );

    i2c_rx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .i2c_clk   (i2c_clk),
        .i2c_rst_n (i2c_rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty),
        .level     (fifo_level)
    );

    i2c_rx_read_port u_read_port (
        .i2c_clk   (i2c_clk),
        .i2c_rst_n (i2c_rst_n),
        .rd_en     (rd_en),
        .pop_data  (pop_data),
        .empty     (empty),
        .pop       (pop),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .underflow (underflow)
    );

endmodule

`default_nettype wire

//--- verification/i2c_rx_assertions.sv
// protocol assertions bound into every receive shifter instance
`timescale 1ns/1ps
`default_nettype none

module i2c_rx_assertions (
    input logic                  i2c_clk,
    input logic                  i2c_rst_n,
    input logic                  push,
    input logic                  full,
    input logic                  sda_drive_low,
    input logic                  byte_done_q,
    input i2c_rx_pkg::rx_state_t state
);

    // a push must never meet a full fifo
    push_not_full: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
        push |-> !full)
        else $error("push while the rx fifo is full");

    ack_only_in_ack: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
        sda_drive_low |-> (state == i2c_rx_pkg::ACK))
        else $error("sda driven low outside the ack state");

    byte_done_pulse: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
        byte_done_q |=> !byte_done_q)
        else $error("byte_done high for more than one cycle");

endmodule

bind i2c_rx_shifter i2c_rx_assertions u_assertions (
    .i2c_clk       (i2c_clk),
    .i2c_rst_n     (i2c_rst_n),
    .push          (push),
    .full          (full),
    .sda_drive_low (sda_drive_low),
    .byte_done_q   (byte_done_q),
    .state         (state)
);

`default_nettype wire

//--- verification/tb_clock_gen.sv
// testbench clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic i2c_clk,
    output logic i2c_rst_n
);

    initial begin
        i2c_clk = 1'b0;
        forever #(PERIOD_NS / 2) i2c_clk = ~i2c_clk;
    end

    // reset released on a rising edge
    initial begin
        i2c_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge i2c_clk);
        i2c_rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/tb_i2c_slave_rx.sv
// testbench for the i2c slave receive path, transactions read from the golden file
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_slave_rx;

    localparam int          NTEST = 7;
    localparam int          WPL   = 17;
    localparam int          HALF  = 20;
    localparam logic [31:0] SEED  = 32'h7024_d608;

    logic                    i2c_clk;
    logic                    i2c_rst_n;
    logic                    scl_line;
    logic                    sda_line;
    logic                    sda_in;
    logic                    enable;
    logic                    gen_call_en;
    logic                    rd_en;
    i2c_rx_pkg::slave_addr_t slave_addr;
    logic                    sda_drive_low;
    i2c_rx_pkg::rx_byte_t    rd_data;
    logic                    rd_valid;
    logic [2:0]              fifo_level;
    logic                    addr_matched;
    logic                    gen_call_rcvd;
    logic                    underflow;
    logic [15:0]             gold [NTEST*WPL];
    i2c_rx_pkg::rx_byte_t    sent [6];
    int errors = 0;
    int checks = 0;
    int test_errs = 0;
    int passed = 0;
    int failed = 0;
    int gcall_pulses = 0;
    int cycles = 0;
    int cycle_limit = 1000000;
    int total_bytes = 0;

    // open drain bus, the slave pulls sda low
    assign sda_in = sda_line & ~sda_drive_low;

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(16)) clk0 (
        .i2c_clk   (i2c_clk),
        .i2c_rst_n (i2c_rst_n)
    );

    i2c_slave_rx_top #(.FIFO_DEPTH(4), .ADDRESS_STEALING(1)) dut0 (
        .i2c_clk       (i2c_clk),
        .i2c_rst_n     (i2c_rst_n),
        .scl_in        (scl_line),
        .sda_in        (sda_in),
        .enable        (enable),
        .slave_addr    (slave_addr),
        .gen_call_en   (gen_call_en),
        .rd_en         (rd_en),
        .sda_drive_low (sda_drive_low),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid),
        .fifo_level    (fifo_level),
        .addr_matched  (addr_matched),
        .gen_call_rcvd (gen_call_rcvd),
        .underflow     (underflow)
    );

    always @(posedge i2c_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    always @(negedge i2c_clk) begin
        if (i2c_rst_n && gen_call_rcvd) begin
            gcall_pulses++;
        end
    end

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge i2c_clk);
    endtask

    task automatic check_value(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("MISMATCH @%0t: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            passed++;
            $display("test %-28s ok", name);
        end else begin
            failed++;
            $display("test %-28s failed with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic start_cond();
        @(posedge i2c_clk);
        sda_line <= 1'b0;
        wait_clocks(HALF);
    endtask

    task automatic stop_cond();
        @(posedge i2c_clk);
        scl_line <= 1'b0;
        wait_clocks(HALF / 2);
        sda_line <= 1'b0;
        wait_clocks(HALF / 2);
        scl_line <= 1'b1;
        wait_clocks(HALF);
        sda_line <= 1'b1;
        wait_clocks(HALF);
    endtask

    // sda changes in the middle of scl low
    task automatic send_bit(input logic b);
        @(posedge i2c_clk);
        scl_line <= 1'b0;
        wait_clocks(HALF / 2);
        sda_line <= b;
        wait_clocks(HALF / 2);
        scl_line <= 1'b1;
        wait_clocks(HALF);
    endtask

    task automatic send_byte(input i2c_rx_pkg::rx_byte_t b, output logic acked,
                             output logic matched);
        for (int i = 7; i >= 0; i--) begin
            send_bit(b[i]);
        end
        @(posedge i2c_clk);
        scl_line <= 1'b0;
        wait_clocks(HALF / 2);
        sda_line <= 1'b1;
        wait_clocks(HALF / 2);
        scl_line <= 1'b1;
        wait_clocks(HALF / 2);
        @(negedge i2c_clk);
        acked   = sda_drive_low;
        matched = addr_matched;
        wait_clocks(HALF / 2);
    endtask

    task automatic read_byte(input i2c_rx_pkg::rx_byte_t exp);
        int waited;
        @(posedge i2c_clk);
        rd_en <= 1'b1;
        @(posedge i2c_clk);
        rd_en <= 1'b0;
        waited = 0;
        @(negedge i2c_clk);
        while (!rd_valid && waited < 8) begin
            @(negedge i2c_clk);
            waited++;
        end
        checks++;
        assert (rd_valid) else begin
            $display("read at %0t returned no rd_valid within 8 cycles", $time);
            errors++;
            test_errs++;
        end
        if (rd_valid) begin
            check_value("rd_data", rd_data, exp);
        end
    endtask

    // 1ii in the expected columns names data slot ii
    function automatic i2c_rx_pkg::rx_byte_t expected_byte(input logic [15:0] word);
        if (word >= 16'h100) begin
            return sent[word - 16'h100];
        end
        return word[7:0];
    endfunction

    task automatic run_test(input int t);
        int                   base;
        int                   ndata;
        int                   nexp;
        logic [15:0]          acks;
        logic                 acked;
        logic                 matched;
        logic                 gcall;
        i2c_rx_pkg::rx_byte_t addr;
        i2c_rx_pkg::rx_byte_t d;
        base  = t * WPL;
        addr  = gold[base][7:0];
        gcall = gold[base+1][0];
        ndata = gold[base+2];
        acks  = gold[base+9];
        nexp  = gold[base+10];
        @(posedge i2c_clk);
        gen_call_en <= gcall;
        gcall_pulses = 0;
        start_cond();
        send_byte(addr, acked, matched);
        check_value("address ack", acked, acks[0]);
        check_value("addr_matched", matched, acks[0]);
        for (int i = 0; i < ndata; i++) begin
            d = (gold[base+3+i] == 16'h100) ? i2c_rx_pkg::rx_byte_t'($urandom) :
                gold[base+3+i][7:0];
            sent[i] = d;
            send_byte(d, acked, matched);
            check_value($sformatf("data byte %0d ack", i), acked, acks[i+1]);
        end
        stop_cond();
        check_value("gen_call_rcvd pulses", gcall_pulses,
                    (gcall && addr == i2c_rx_pkg::GCALL_ADDR && acks[0]) ? 1 : 0);
        for (int i = 0; i < nexp; i++) begin
            read_byte(expected_byte(gold[base+11+i]));
        end
        wait_clocks(2);
        @(negedge i2c_clk);
        check_value("fifo_level after drain", fifo_level, 0);
        report_test($sformatf("address byte %02h", addr));
        wait_clocks($urandom_range(8, 40));
    endtask

    initial begin
        void'($urandom(SEED));
        scl_line    = 1'b1;
        sda_line    = 1'b1;
        enable      = 1'b1;
        gen_call_en = 1'b0;
        rd_en       = 1'b0;
        slave_addr  = 7'h52;
        $readmemh("verification/i2c_rx_golden.txt", gold);
        for (int t = 0; t < NTEST; t++) begin
            total_bytes += 1 + gold[t*WPL+2];
        end
        cycle_limit = total_bytes * (9 * 2 * HALF + i2c_rx_pkg::SYNC_STAGES + 1)
                      + NTEST * 400 + 1000;

        wait (i2c_rst_n);
        @(negedge i2c_clk);
        check_value("sda_drive_low after reset", sda_drive_low, 0);
        check_value("rd_valid after reset", rd_valid, 0);
        check_value("addr_matched after reset", addr_matched, 0);
        check_value("underflow after reset", underflow, 0);
        check_value("fifo_level after reset", fifo_level, 0);
        report_test("reset values");

        for (int t = 0; t < NTEST; t++) begin
            run_test(t);
        end

        // one read of the empty fifo
        check_value("underflow before empty read", underflow, 0);
        @(posedge i2c_clk);
        rd_en <= 1'b1;
        @(posedge i2c_clk);
        rd_en <= 1'b0;
        @(negedge i2c_clk);
        check_value("underflow after empty read", underflow, 1);
        report_test("underflow on empty read");

        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 passed + failed, passed, failed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/i2c_rx_golden.txt
// addr gcall ndata d0..d5 (100 = random byte) acks (bit0 address, bit i data byte i)
// nexp e0..e5 (1ii = the byte sent in data slot ii)
a4 0 3 100 100 100 0 0 0 0f 3 100 101 102 0 0 0
a6 0 1 100 0 0 0 0 0 03 1 100 0 0 0 0 0
a0 0 1 55 0 0 0 0 0 00 0 0 0 0 0 0 0
a5 0 1 66 0 0 0 0 0 00 0 0 0 0 0 0 0
00 1 1 100 0 0 0 0 0 03 1 100 0 0 0 0 0
00 0 1 77 0 0 0 0 0 00 0 0 0 0 0 0 0
a4 0 6 100 100 100 100 100 100 1f 4 100 101 102 103 0 0

//--- build.f
logic/i2c_rx_pkg.sv
logic/i2c_rx_byte_if.sv
logic/i2c_rx_shifter.sv
logic/i2c_addr_matcher.sv
logic/i2c_rx_fifo.sv
logic/i2c_rx_read_port.sv
logic/i2c_slave_rx_top.sv
verification/i2c_rx_assertions.sv
verification/tb_clock_gen.sv
verification/tb_i2c_slave_rx.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_i2c_slave_rx
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
